// File: lsu_lsc_ctl.f
common/lsu_map_pkg.sv
common/lsu_types_pkg.sv
common/lsu_dc1_if.sv
addr/lsu_decode.sv
addr/lsu_addrcheck.sv
logic/lsu_pipe.sv
logic/lsu_load_fmt.sv
logic/lsu_lsc_ctl.sv
dv/lsu_lsc_ctl_asserts.sv
dv/lsu_lsc_ctl_tb.sv

// File: Makefile
# Verilator build and run for the load/store control pipeline

TOP := lsu_lsc_ctl_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f lsu_lsc_ctl.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "test failed" sim.log; then exit 1; fi
	@grep -q "test passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module lsu_lsc_ctl -f lsu_lsc_ctl.f

clean:
	rm -rf obj_dir sim.log

// File: dv/lsu_lsc_ctl_tb.sv
// Testbench for the load/store control pipeline: clock, reset, random stimulus, model, checks

`timescale 1ns/100ps
`default_nettype none

module lsu_lsc_ctl_tb;
   import lsu_map_pkg::*;

   localparam int NUM_CYCLES = 3000;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        core_valid, core_load, core_store, core_unsign;
   logic [1:0]  core_size;
   logic [31:0] rs1;
   logic [11:0] offset;
   logic        dma_req, dma_write;
   logic [1:0]  dma_size;
   logic [31:0] dma_addr;
   logic        flush_dc2_up, flush_dc3, flush_dc4, flush_dc5;
   logic        ld_bus_error_dc3;
   logic [31:0] ld_data_dc3, bus_read_data_dc3;
   logic [31:0] addr_dc1, addr_dc5, error_addr_dc3, result_dc3, result_dc4;
   logic        exc_dc2, addr_in_dccm_dc3, addr_in_pic_dc3, addr_external_dc3;
   logic        error_exc_valid_dc3, error_exc_type_dc3, error_inst_store_dc3, commit_dc5;

   // Reference model state, index is the stage number
   logic        m_valid [1:5];
   logic        m_dma [1:5];
   logic        m_load [1:5];
   logic        m_store [1:5];
   logic        m_unsign [1:5];
   logic [1:0]  m_size [1:5];
   logic [31:0] m_addr [1:5];
   logic        m_dccm [2:3];
   logic        m_pic [2:3];
   logic        m_ext [2:3];
   logic        m_acc [2:3];
   logic        m_mis [2:3];
   logic [31:0] m_res4;
   logic [31:0] exp_res3;

   lsu_lsc_ctl dut (.*);

   always #50 clk = ~clk;

   // ********************
   // Checking helpers
   // ********************
   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("mismatch %s expected %h actual %h", name, exp, act);
         $display("test failed");
         $fatal(1, "first error");
      end
   endtask

   // 0 external, 1 DCCM, 2 PIC
   function automatic logic [1:0] region_of(input logic [31:0] a);
      if (a >= DCCM_BASE && a < DCCM_BASE + DCCM_BYTES) return 2'd1;
      if (a >= PIC_BASE && a < PIC_BASE + PIC_BYTES) return 2'd2;
      return 2'd0;
   endfunction

   // Region and fault flags of the item sitting in DC1
   task automatic dc1_flags(output logic dccm, output logic pic, output logic ext,
                            output logic acc, output logic mis);
      logic [31:0] last;
      logic [1:0]  rs;
      logic [1:0]  re;
      last = m_addr[1] + ((32'd1 << m_size[1]) - 32'd1);
      rs   = region_of(m_addr[1]);
      re   = region_of(last);
      dccm = (rs == 2'd1);
      pic  = (rs == 2'd2);
      ext  = (rs == 2'd0);
      acc  = (rs != re) || (pic && m_size[1] != 2'd2);
      case (m_size[1])
         2'd1:    mis = m_addr[1][0];
         2'd2:    mis = |m_addr[1][1:0];
         2'd3:    mis = ~m_dma[1];
         default: mis = 1'b0;
      endcase
   endtask

   // ********************
   // Model update at a rising edge
   // ********************
   task automatic step_model();
      logic d, p, e, a, m;
      logic kill [2:5];
      kill[2] = flush_dc2_up;
      kill[3] = flush_dc2_up;
      kill[4] = flush_dc3;
      kill[5] = flush_dc4;
      m_res4 = exp_res3;
      for (int s = 5; s >= 2; s--) begin
         m_valid[s]  = m_valid[s-1] & ~(kill[s] & ~m_dma[s-1]);
         m_dma[s]    = m_dma[s-1];
         m_load[s]   = m_load[s-1];
         m_store[s]  = m_store[s-1];
         m_unsign[s] = m_unsign[s-1];
         m_size[s]   = m_size[s-1];
         m_addr[s]   = m_addr[s-1];
      end
      m_dccm[3] = m_dccm[2];
      m_pic[3]  = m_pic[2];
      m_ext[3]  = m_ext[2];
      m_acc[3]  = m_acc[2];
      m_mis[3]  = m_mis[2];
      dc1_flags(d, p, e, a, m);
      m_dccm[2] = d;
      m_pic[2]  = p;
      m_ext[2]  = e;
      m_acc[2]  = a;
      m_mis[2]  = m;
      if (dma_req) begin
         m_valid[1]  = 1'b1;
         m_dma[1]    = 1'b1;
         m_load[1]   = ~dma_write;
         m_store[1]  = dma_write;
         m_unsign[1] = 1'b0;
         m_size[1]   = dma_size;
         m_addr[1]   = dma_addr;
      end else begin
         m_valid[1]  = core_valid & ~flush_dc2_up;
         m_dma[1]    = 1'b0;
         m_load[1]   = core_load;
         m_store[1]  = core_store;
         m_unsign[1] = core_unsign;
         m_size[1]   = core_size;
         m_addr[1]   = rs1 + {{20{offset[11]}}, offset};
      end
   endtask

   task automatic check_outputs();
      logic [31:0] raw;
      logic        err;
      raw = m_ext[3] ? bus_read_data_dc3 : ld_data_dc3;
      case (m_size[3])
         2'd0:    exp_res3 = {{24{~m_unsign[3] & raw[7]}}, raw[7:0]};
         2'd1:    exp_res3 = {{16{~m_unsign[3] & raw[15]}}, raw[15:0]};
         2'd2:    exp_res3 = raw;
         default: exp_res3 = 32'd0;
      endcase
      err = (m_acc[3] | m_mis[3] | ld_bus_error_dc3) & m_valid[3] & ~m_dma[3] & ~flush_dc3;
      compare("addr_dc1", m_addr[1], addr_dc1);
      compare("exc_dc2", 32'(m_valid[2] & (m_acc[2] | m_mis[2])), 32'(exc_dc2));
      compare("in_dccm_dc3", 32'(m_dccm[3]), 32'(addr_in_dccm_dc3));
      compare("in_pic_dc3", 32'(m_pic[3]), 32'(addr_in_pic_dc3));
      compare("external_dc3", 32'(m_ext[3]), 32'(addr_external_dc3));
      compare("error_exc_valid_dc3", 32'(err), 32'(error_exc_valid_dc3));
      compare("error_exc_type_dc3", 32'(!m_mis[3]), 32'(error_exc_type_dc3));
      compare("error_inst_store_dc3", 32'(m_store[3]), 32'(error_inst_store_dc3));
      compare("error_addr_dc3", m_addr[3], error_addr_dc3);
      compare("result_dc3", exp_res3, result_dc3);
      compare("result_dc4", m_res4, result_dc4);
      compare("addr_dc5", m_addr[5], addr_dc5);
      compare("commit_dc5",
              32'(m_valid[5] & (m_load[5] | m_store[5]) & ~m_dma[5] & ~flush_dc5),
              32'(commit_dc5));
   endtask

   // ********************
   // Stimulus
   // ********************
   function automatic logic [31:0] pick_address();
      logic [31:0] a;
      case ($urandom_range(0, 3))
         0:       a = DCCM_BASE + $urandom_range(0, 32'hFFFF);
         1:       a = PIC_BASE + $urandom_range(0, 32'h7FFF);
         2:       a = $urandom;
         default: begin
            case ($urandom_range(0, 3))
               0:       a = DCCM_BASE;
               1:       a = DCCM_BASE + DCCM_BYTES;
               2:       a = PIC_BASE;
               default: a = PIC_BASE + PIC_BYTES;
            endcase
            a = a - $urandom_range(0, 7);
         end
      endcase
      // Favour aligned addresses now and then
      if ($urandom_range(0, 1) == 0) a[1:0] = 2'b00;
      return a;
   endfunction

   task automatic drive_random();
      logic [31:0] target;
      target            = pick_address();
      dma_req           = ($urandom_range(0, 3) == 0);
      dma_write         = $urandom_range(0, 1) == 1;
      dma_size          = 2'($urandom_range(0, 3));
      dma_addr          = target;
      core_valid        = ($urandom_range(0, 3) != 0);
      core_load         = ($urandom_range(0, 2) != 2);
      core_store        = ~core_load & ($urandom_range(0, 3) != 0);
      core_unsign       = $urandom_range(0, 1) == 1;
      core_size         = 2'($urandom_range(0, 3));
      offset            = 12'($urandom);
      rs1               = target - {{20{offset[11]}}, offset};
      flush_dc2_up      = ($urandom_range(0, 7) == 0);
      flush_dc3         = ($urandom_range(0, 7) == 0);
      flush_dc4         = ($urandom_range(0, 7) == 0);
      flush_dc5         = ($urandom_range(0, 7) == 0);
      ld_bus_error_dc3  = ($urandom_range(0, 7) == 0);
      ld_data_dc3       = $urandom;
      bus_read_data_dc3 = $urandom;
   endtask

   task automatic drive_idle();
      {core_valid, core_load, core_store, core_unsign, core_size} = '0;
      {rs1, offset, dma_req, dma_write, dma_size, dma_addr} = '0;
      {flush_dc2_up, flush_dc3, flush_dc4, flush_dc5} = '0;
      {ld_bus_error_dc3, ld_data_dc3, bus_read_data_dc3} = '0;
   endtask

   task automatic timeout_fail(input string what);
      $display("timeout while waiting for %s", what);
      $display("test failed");
      $fatal(1, "timeout");
   endtask

   // ********************
   // Main sequence
   // ********************
   initial begin
      int guard;
      logic busy;
      void'($urandom(32'hd902b04f));
      rst_n = 1'b0;
      drive_idle();
      for (int s = 1; s <= 5; s++) begin
         {m_valid[s], m_dma[s], m_load[s], m_store[s], m_unsign[s]} = '0;
         m_size[s] = '0;
         m_addr[s] = '0;
      end
      for (int s = 2; s <= 3; s++) begin
         {m_dccm[s], m_pic[s], m_ext[s], m_acc[s], m_mis[s]} = '0;
      end
      m_res4   = '0;
      exp_res3 = '0;
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;

      guard = 0;
      while (addr_dc1 !== 32'd0 || commit_dc5 !== 1'b0) begin
         guard++;
         if (guard > 10) timeout_fail("reset outputs");
         @(posedge clk);
      end

      for (int i = 0; i < NUM_CYCLES; i++) begin
         drive_random();
         @(negedge clk);
         check_outputs();
         @(posedge clk);
         step_model();
         #1;
      end

      // Let the pipeline drain
      drive_idle();
      guard = 0;
      busy  = 1'b1;
      while (busy) begin
         guard++;
         if (guard > 20) timeout_fail("pipeline drain");
         @(negedge clk);
         check_outputs();
         @(posedge clk);
         step_model();
         #1;
         busy = m_valid[1] | m_valid[2] | m_valid[3] | m_valid[4] | m_valid[5];
      end

      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/lsu_lsc_ctl_asserts.sv
// Concurrent assertions on the load/store control top level and their bind

`timescale 1ns/100ps
`default_nettype none

module lsu_lsc_ctl_asserts (
   input logic        clk,
   input logic        rst_n,
   input logic        valid_dc3,
   input logic        addr_in_dccm_dc3,
   input logic        addr_in_pic_dc3,
   input logic        addr_external_dc3,
   input logic        flush_dc3,
   input logic        flush_dc5,
   input logic        error_exc_valid_dc3,
   input logic        error_inst_store_dc3,
   input logic [31:0] error_addr_dc3,
   input logic        commit_dc5,
   input logic        exc_dc2,
   input logic [31:0] addr_dc1,
   input logic [31:0] addr_dc5,
   input logic [31:0] result_dc4
);

   // ********************
   // Region and strobes
   // ********************
   a_one_region: assert property (@(posedge clk) disable iff (!rst_n)
      valid_dc3 |-> $onehot({addr_in_dccm_dc3, addr_in_pic_dc3, addr_external_dc3}))
      else $error("more or fewer than one region flag at DC3");

   a_commit_flush: assert property (@(posedge clk) disable iff (!rst_n)
      !(commit_dc5 && flush_dc5))
      else $error("commit during DC5 flush");

   a_error_flush: assert property (@(posedge clk) disable iff (!rst_n)
      !(error_exc_valid_dc3 && flush_dc3))
      else $error("error report during DC3 flush");

   // Registers settle one edge into reset
   a_reset_quiet: assert property (@(posedge clk)
      (!rst_n && $past(!rst_n)) |-> (!commit_dc5 && !exc_dc2 && !error_exc_valid_dc3 &&
         !error_inst_store_dc3 && error_addr_dc3 == '0 &&
         addr_dc1 == '0 && addr_dc5 == '0 && result_dc4 == '0 &&
         !addr_in_dccm_dc3 && !addr_in_pic_dc3 && !addr_external_dc3))
      else $error("outputs active during reset");

endmodule

bind lsu_lsc_ctl lsu_lsc_ctl_asserts u_asserts (
   .clk                  (clk),
   .rst_n                (rst_n),
   .valid_dc3            (pkt_dc3.valid),
   .addr_in_dccm_dc3     (addr_in_dccm_dc3),
   .addr_in_pic_dc3      (addr_in_pic_dc3),
   .addr_external_dc3    (addr_external_dc3),
   .flush_dc3            (flush_dc3),
   .flush_dc5            (flush_dc5),
   .error_exc_valid_dc3  (error_exc_valid_dc3),
   .error_inst_store_dc3 (error_inst_store_dc3),
   .error_addr_dc3       (error_addr_dc3),
   .commit_dc5           (commit_dc5),
   .exc_dc2              (exc_dc2),
   .addr_dc1             (addr_dc1),
   .addr_dc5             (addr_dc5),
   .result_dc4           (result_dc4)
);

`default_nettype wire

// File: logic/lsu_lsc_ctl.sv
// Load/store control top level connecting decode, address check, pipeline and load format

`timescale 1ns/100ps
`default_nettype none

module lsu_lsc_ctl (
   input  logic                                 clk,
   input  logic                                 rst_n,
   // Core request
   input  logic                                 core_valid,
   input  logic                                 core_load,
   input  logic                                 core_store,
   input  logic                                 core_unsign,
   input  logic [1:0]                           core_size,
   input  logic [lsu_map_pkg::XLEN-1:0]         rs1,
   input  logic [lsu_map_pkg::OFFSET_W-1:0]     offset,
   // DMA request
   input  logic                                 dma_req,
   input  logic                                 dma_write,
   input  logic [1:0]                           dma_size,
   input  logic [lsu_map_pkg::XLEN-1:0]         dma_addr,
   // Flushes
   input  logic                                 flush_dc2_up,
   input  logic                                 flush_dc3,
   input  logic                                 flush_dc4,
   input  logic                                 flush_dc5,
   // DC3 load return
   input  logic                                 ld_bus_error_dc3,
   input  logic [lsu_map_pkg::XLEN-1:0]         ld_data_dc3,
   input  logic [lsu_map_pkg::XLEN-1:0]         bus_read_data_dc3,
   // Results
   output logic [lsu_map_pkg::XLEN-1:0]         addr_dc1,
   output logic [lsu_map_pkg::XLEN-1:0]         addr_dc5,
   output logic                                 exc_dc2,
   output logic                                 addr_in_dccm_dc3,
   output logic                                 addr_in_pic_dc3,
   output logic                                 addr_external_dc3,
   output logic                                 error_exc_valid_dc3,
   output logic                                 error_exc_type_dc3,
   output logic                                 error_inst_store_dc3,
   output logic [lsu_map_pkg::XLEN-1:0]         error_addr_dc3,
   output logic [lsu_map_pkg::XLEN-1:0]         result_dc3,
   output logic [lsu_map_pkg::XLEN-1:0]         result_dc4,
   output logic                                 commit_dc5
);
   import lsu_types_pkg::*;

   lsu_pkt_t   pkt_dc3;
   lsu_error_t error_dc3;

   lsu_dc1_if dc1_bus ();

   // ********************
   // DC1
   // ********************
   lsu_decode u_decode (
      .clk          (clk),
      .rst_n        (rst_n),
      .core_valid   (core_valid),
      .core_load    (core_load),
      .core_store   (core_store),
      .core_unsign  (core_unsign),
      .core_size    (core_size),
      .rs1          (rs1),
      .offset       (offset),
      .dma_req      (dma_req),
      .dma_write    (dma_write),
      .dma_size     (dma_size),
      .dma_addr     (dma_addr),
      .flush_dc2_up (flush_dc2_up),
      .dc1          (dc1_bus.gen)
   );

   lsu_addrcheck u_addrcheck (
      .dc1 (dc1_bus.chk)
   );

   // ********************
   // DC2 to DC5
   // ********************
   lsu_pipe u_pipe (
      .clk              (clk),
      .rst_n            (rst_n),
      .flush_dc2_up     (flush_dc2_up),
      .flush_dc3        (flush_dc3),
      .flush_dc4        (flush_dc4),
      .flush_dc5        (flush_dc5),
      .ld_bus_error_dc3 (ld_bus_error_dc3),
      .dc1              (dc1_bus.pipe),
      .pkt_dc3          (pkt_dc3),
      .external_dc3     (addr_external_dc3),
      .in_dccm_dc3      (addr_in_dccm_dc3),
      .in_pic_dc3       (addr_in_pic_dc3),
      .addr_dc5         (addr_dc5),
      .exc_dc2          (exc_dc2),
      .error_dc3        (error_dc3),
      .commit_dc5       (commit_dc5)
   );

   lsu_load_fmt u_load_fmt (
      .clk               (clk),
      .rst_n             (rst_n),
      .pkt_dc3           (pkt_dc3),
      .external_dc3      (addr_external_dc3),
      .ld_data_dc3       (ld_data_dc3),
      .bus_read_data_dc3 (bus_read_data_dc3),
      .result_dc3        (result_dc3),
      .result_dc4        (result_dc4)
   );

   // Flatten the bundles onto the top level ports
   assign addr_dc1             = dc1_bus.addr;
   assign error_exc_valid_dc3  = error_dc3.exc_valid;
   assign error_exc_type_dc3   = error_dc3.exc_type;
   assign error_inst_store_dc3 = error_dc3.inst_type;
   assign error_addr_dc3       = error_dc3.addr;

endmodule

`default_nettype wire

// File: logic/lsu_load_fmt.sv
// Load data select, size and sign extension at DC3 and the DC4 result register

`timescale 1ns/100ps
`default_nettype none

module lsu_load_fmt (
   input  logic                             clk,
   input  logic                             rst_n,
   input  lsu_types_pkg::lsu_pkt_t          pkt_dc3,
   input  logic                             external_dc3,
   input  logic [lsu_map_pkg::XLEN-1:0]     ld_data_dc3,
   input  logic [lsu_map_pkg::XLEN-1:0]     bus_read_data_dc3,
   output logic [lsu_map_pkg::XLEN-1:0]     result_dc3,
   output logic [lsu_map_pkg::XLEN-1:0]     result_dc4
);
   import lsu_map_pkg::*;
   import lsu_types_pkg::*;

   logic [XLEN-1:0] raw_dc3;
   logic            byte_fill;
   logic            half_fill;

   // External accesses return on the bus, the rest from local memory
   assign raw_dc3 = external_dc3 ? bus_read_data_dc3 : ld_data_dc3;

   // Fill bit for the upper part
   assign byte_fill = ~pkt_dc3.unsign & raw_dc3[7];
   assign half_fill = ~pkt_dc3.unsign & raw_dc3[15];

   always_comb begin
      case (pkt_dc3.size)
         SZ_BYTE:  result_dc3 = {{(XLEN-8){byte_fill}}, raw_dc3[7:0]};
         SZ_HALF:  result_dc3 = {{(XLEN-16){half_fill}}, raw_dc3[15:0]};
         SZ_WORD:  result_dc3 = raw_dc3;
         default:  result_dc3 = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result_dc4 <= '0;
      end else begin
         result_dc4 <= result_dc3;
      end
   end

endmodule

`default_nettype wire

// File: logic/lsu_pipe.sv
// DC2 to DC5 packet and address pipeline with flush, exception, error report and commit

`timescale 1ns/100ps
`default_nettype none

module lsu_pipe (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             flush_dc2_up,
   input  logic                             flush_dc3,
   input  logic                             flush_dc4,
   input  logic                             flush_dc5,
   input  logic                             ld_bus_error_dc3,
   lsu_dc1_if.pipe                          dc1,
   output lsu_types_pkg::lsu_pkt_t          pkt_dc3,
   output logic                             external_dc3,
   output logic                             in_dccm_dc3,
   output logic                             in_pic_dc3,
   output logic [lsu_map_pkg::XLEN-1:0]     addr_dc5,
   output logic                             exc_dc2,
   output lsu_types_pkg::lsu_error_t        error_dc3,
   output logic                             commit_dc5
);
   import lsu_map_pkg::*;
   import lsu_types_pkg::*;

   lsu_pkt_t        pkt_q  [2:5];
   lsu_pkt_t        pkt_in [2:5];
   logic [XLEN-1:0] addr_q [2:5];
   logic [5:2]      kill;
   logic            access_fault_dc2;
   logic            misaligned_fault_dc2;
   logic            in_dccm_dc2;
   logic            in_pic_dc2;
   logic            external_dc2;
   logic            access_fault_dc3;
   logic            misaligned_fault_dc3;

   // ********************
   // Valid tracking
   // ********************

   // Flush that applies on the way into each stage
   assign kill = {flush_dc4, flush_dc3, flush_dc2_up, flush_dc2_up};

   always_comb begin
      pkt_in[2] = dc1.pkt;
      for (int s = 3; s <= 5; s++) begin
         pkt_in[s] = pkt_q[s-1];
      end
      // DMA traffic ignores flushes
      for (int s = 2; s <= 5; s++) begin
         pkt_in[s].valid = pkt_in[s].valid & ~(kill[s] & ~pkt_in[s].dma);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int s = 2; s <= 5; s++) begin
            pkt_q[s]  <= '0;
            addr_q[s] <= '0;
         end
         access_fault_dc2     <= 1'b0;
         misaligned_fault_dc2 <= 1'b0;
         in_dccm_dc2          <= 1'b0;
         in_pic_dc2           <= 1'b0;
         external_dc2         <= 1'b0;
         access_fault_dc3     <= 1'b0;
         misaligned_fault_dc3 <= 1'b0;
         in_dccm_dc3          <= 1'b0;
         in_pic_dc3           <= 1'b0;
         external_dc3         <= 1'b0;
      end else begin
         for (int s = 2; s <= 5; s++) begin
            pkt_q[s] <= pkt_in[s];
         end
         addr_q[2] <= dc1.addr;
         for (int s = 3; s <= 5; s++) begin
            addr_q[s] <= addr_q[s-1];
         end
         access_fault_dc2     <= dc1.access_fault;
         misaligned_fault_dc2 <= dc1.misaligned_fault;
         in_dccm_dc2          <= dc1.in_dccm;
         in_pic_dc2           <= dc1.in_pic;
         external_dc2         <= dc1.external;
         access_fault_dc3     <= access_fault_dc2;
         misaligned_fault_dc3 <= misaligned_fault_dc2;
         in_dccm_dc3          <= in_dccm_dc2;
         in_pic_dc3           <= in_pic_dc2;
         external_dc3         <= external_dc2;
      end
   end

   assign pkt_dc3  = pkt_q[3];
   assign addr_dc5 = addr_q[5];

   // ********************
   // Exception and error report
   // ********************
   assign exc_dc2 = (access_fault_dc2 | misaligned_fault_dc2) & pkt_q[2].valid;

   always_comb begin
      error_dc3.exc_valid = (access_fault_dc3 | misaligned_fault_dc3 | ld_bus_error_dc3) &
                            pkt_q[3].valid & ~pkt_q[3].dma & ~flush_dc3;
      error_dc3.exc_type  = ~misaligned_fault_dc3;
      error_dc3.inst_type = pkt_q[3].store;
      error_dc3.addr      = addr_q[3];
   end

   // Commit only core loads and stores that survive the DC5 flush
   assign commit_dc5 = pkt_q[5].valid & (pkt_q[5].load | pkt_q[5].store) &
                       ~pkt_q[5].dma & ~flush_dc5;

endmodule

`default_nettype wire

// File: addr/lsu_addrcheck.sv
// DC1 memory map decode with access fault and misaligned fault detection

`timescale 1ns/100ps
`default_nettype none

module lsu_addrcheck (
   lsu_dc1_if.chk dc1
);
   import lsu_map_pkg::*;
   import lsu_types_pkg::*;

   logic start_dccm;
   logic start_pic;
   logic end_dccm;
   logic end_pic;
   logic cross_region;
   logic pic_not_word;

   // Unsigned wrap makes one compare cover both window bounds
   function automatic logic in_window(input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] base,
                                      input logic [XLEN-1:0] bytes);
      logic [XLEN-1:0] rel;
      rel = a - base;
      return rel < bytes;
   endfunction

   // ********************
   // Region decode
   // ********************
   assign start_dccm = in_window(dc1.addr,     DCCM_BASE, DCCM_BYTES);
   assign start_pic  = in_window(dc1.addr,     PIC_BASE,  PIC_BYTES);
   assign end_dccm   = in_window(dc1.end_addr, DCCM_BASE, DCCM_BYTES);
   assign end_pic    = in_window(dc1.end_addr, PIC_BASE,  PIC_BYTES);

   assign dc1.in_dccm  = start_dccm;
   assign dc1.in_pic   = start_pic;
   assign dc1.external = ~start_dccm & ~start_pic;

   // ********************
   // Faults
   // ********************

   // Start and end bytes must sit in the same region
   assign cross_region = (start_dccm != end_dccm) | (start_pic != end_pic);
   assign pic_not_word = start_pic & (dc1.pkt.size != SZ_WORD);

   assign dc1.access_fault = cross_region | pic_not_word;

   always_comb begin
      case (dc1.pkt.size)
         SZ_HALF:  dc1.misaligned_fault = dc1.addr[0];
         SZ_WORD:  dc1.misaligned_fault = |dc1.addr[1:0];
         SZ_DWORD: dc1.misaligned_fault = ~dc1.pkt.dma;  // core has no dword access
         default:  dc1.misaligned_fault = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// File: addr/lsu_decode.sv
// Core and DMA request select, DC1 registers and start and end address generation

`timescale 1ns/100ps
`default_nettype none

module lsu_decode (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  core_valid,
   input  logic                                  core_load,
   input  logic                                  core_store,
   input  logic                                  core_unsign,
   input  logic [1:0]                            core_size,
   input  logic [lsu_map_pkg::XLEN-1:0]          rs1,
   input  logic [lsu_map_pkg::OFFSET_W-1:0]      offset,
   input  logic                                  dma_req,
   input  logic                                  dma_write,
   input  logic [1:0]                            dma_size,
   input  logic [lsu_map_pkg::XLEN-1:0]          dma_addr,
   input  logic                                  flush_dc2_up,
   lsu_dc1_if.gen                                dc1
);
   import lsu_map_pkg::*;
   import lsu_types_pkg::*;

   lsu_pkt_t              core_pkt_d;
   lsu_pkt_t              dma_pkt_d;
   lsu_pkt_t              pkt_d;
   lsu_pkt_t              pkt_dc1;
   logic [XLEN-1:0]       base_d;
   logic [OFFSET_W-1:0]   offset_d;
   logic [XLEN-1:0]       base_dc1;
   logic [OFFSET_W-1:0]   offset_dc1;
   logic [XLEN-1:0]       addr_dc1;
   logic [2:0]            last_byte_dc1;

   // ********************
   // D stage request select
   // ********************
   always_comb begin
      core_pkt_d        = '0;
      core_pkt_d.valid  = core_valid & ~flush_dc2_up;
      core_pkt_d.load   = core_load;
      core_pkt_d.store  = core_store;
      core_pkt_d.unsign = core_unsign;
      core_pkt_d.size   = lsu_size_e'(core_size);

      dma_pkt_d         = '0;
      dma_pkt_d.valid   = 1'b1;
      dma_pkt_d.dma     = 1'b1;
      dma_pkt_d.load    = ~dma_write;
      dma_pkt_d.store   = dma_write;
      dma_pkt_d.size    = lsu_size_e'(dma_size);

      // DMA wins over the core
      pkt_d = dma_req ? dma_pkt_d : core_pkt_d;
   end

   // DMA address is already complete, so no offset
   assign base_d   = dma_req ? dma_addr : rs1;
   assign offset_d = dma_req ? '0 : offset;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pkt_dc1    <= '0;
         base_dc1   <= '0;
         offset_dc1 <= '0;
      end else begin
         pkt_dc1    <= pkt_d;
         base_dc1   <= base_d;
         offset_dc1 <= offset_d;
      end
   end

   // ********************
   // DC1 address generation
   // ********************
   assign addr_dc1 = base_dc1 + {{(XLEN-OFFSET_W){offset_dc1[OFFSET_W-1]}}, offset_dc1};

   // Offset of the last byte touched
   always_comb begin
      case (pkt_dc1.size)
         SZ_BYTE:  last_byte_dc1 = 3'd0;
         SZ_HALF:  last_byte_dc1 = 3'd1;
         SZ_WORD:  last_byte_dc1 = 3'd3;
         default:  last_byte_dc1 = 3'd7;
      endcase
   end

   assign dc1.pkt      = pkt_dc1;
   assign dc1.addr     = addr_dc1;
   assign dc1.end_addr = addr_dc1 + {{(XLEN-3){1'b0}}, last_byte_dc1};

endmodule

`default_nettype wire

// File: common/lsu_dc1_if.sv
// DC1 stage bundle: packet, start and end address, region and fault flags

`timescale 1ns/100ps
`default_nettype none

interface lsu_dc1_if;
   import lsu_map_pkg::*;
   import lsu_types_pkg::*;

   lsu_pkt_t        pkt;
   logic [XLEN-1:0] addr;
   logic [XLEN-1:0] end_addr;
   logic            in_dccm;
   logic            in_pic;
   logic            external;
   logic            access_fault;
   logic            misaligned_fault;

   // Address generation side
   modport gen  (output pkt, addr, end_addr);

   // Memory map check side
   modport chk  (input  pkt, addr, end_addr,
                 output in_dccm, in_pic, external, access_fault, misaligned_fault);

   // Pipeline side
   modport pipe (input  pkt, addr, end_addr, in_dccm, in_pic, external,
                        access_fault, misaligned_fault);

endinterface

`default_nettype wire

// File: common/lsu_types_pkg.sv
// Access size enum, load/store control packet and error report types

`default_nettype none

package lsu_types_pkg;

   // ********************
   // Access size
   // ********************

   // Same code as the DMA size field
   typedef enum logic [1:0] {
      SZ_BYTE  = 2'd0,
      SZ_HALF  = 2'd1,
      SZ_WORD  = 2'd2,
      SZ_DWORD = 2'd3
   } lsu_size_e;

   // ********************
   // Control packet
   // ********************
   typedef struct packed {
      logic      valid;
      logic      dma;      // Request came from the DMA port
      logic      load;
      logic      store;
      logic      unsign;   // Zero extend on load
      lsu_size_e size;
   } lsu_pkt_t;

   // ********************
   // Error report
   // ********************
   typedef struct packed {
      logic                              exc_valid;
      logic                              exc_type;   // 1 access or bus fault, 0 misaligned
      logic                              inst_type;  // 1 store
      logic [lsu_map_pkg::XLEN-1:0]      addr;
   } lsu_error_t;

endpackage

`default_nettype wire

// File: common/lsu_map_pkg.sv
// Data widths and the DCCM and PIC address windows of the load/store unit

`default_nettype none

package lsu_map_pkg;

   // ********************
   // Widths
   // ********************
   localparam int XLEN     = 32;
   localparam int OFFSET_W = 12;

   // ********************
   // Memory regions
   // ********************

   // Data closely coupled memory
   localparam logic [XLEN-1:0] DCCM_BASE  = 32'hF004_0000;
   localparam logic [XLEN-1:0] DCCM_BYTES = 32'h0001_0000;

   // Interrupt controller registers, word access only
   localparam logic [XLEN-1:0] PIC_BASE   = 32'hF00C_0000;
   localparam logic [XLEN-1:0] PIC_BYTES  = 32'h0000_8000;

   // Everything outside both windows goes to the external bus

endpackage

`default_nettype wire
